// ==== src.f ====
+incdir+tb
rtl/avr_pkg.sv
rtl/instr_decoder.sv
rtl/alu_unit.sv
rtl/pointer_unit.sv
rtl/register_file.sv
rtl/core_sequencer.sv
rtl/avr_core.sv
tb/avr_core_tb.sv

// ==== tb/avr_iss_model.svh ====
// --------------------------------------------------
// Random program generator
// --------------------------------------------------
function automatic int unsigned rnd(input int unsigned n);
    return $unsigned($random(seed)) % n;
endfunction

function automatic logic [15:0] random_instr();
    logic [4:0] d;
    logic [4:0] r;
    logic [7:0] k;
    logic       st;
    logic [3:0] c4;
    logic [5:0] op;
    d  = 5'(rnd(32));
    r  = 5'(rnd(32));
    k  = 8'(rnd(256));
    st = 1'(rnd(2));
    case (rnd(10))
        0: return {4'b1110, k[7:4], d[3:0], k[3:0]};                 // LDI
        1: begin
            case (rnd(10))
                0: op = 6'b000001;  1: op = 6'b000010;  2: op = 6'b000011;
                3: op = 6'b000101;  4: op = 6'b000110;  5: op = 6'b000111;
                6: op = 6'b001000;  7: op = 6'b001001;  8: op = 6'b001010;
                default: op = 6'b001011;
            endcase
            return {op, r[4], d, r[3:0]};
        end
        2: begin
            c4 = 4'b0011 + 4'(rnd(5));                              // CPI..ANDI
            return {c4, k[7:4], d[3:0], k[3:0]};
        end
        3: begin
            case (rnd(8))
                0: c4 = 4'h0;  1: c4 = 4'h1;  2: c4 = 4'h2;  3: c4 = 4'h3;
                4: c4 = 4'h5;  5: c4 = 4'h6;  6: c4 = 4'h7;
                default: c4 = 4'hA;
            endcase
            return {7'b1001010, d, c4};
        end
        4: return {4'b1100, 12'(rnd(32))};                           // Forward RJMP
        5: return {5'b11110, st, 7'(rnd(32)), 3'(rnd(8))};
        6: begin
            c4 = 4'b1100 + 4'(rnd(3));                              // X, X+, -X
            return {6'b100100, st, d, c4};
        end
        7: return {6'b100000, st, d, r[0], 3'b000};                  // Plain Y or Z
        8: begin
            case (rnd(4))
                0: c4 = 4'b1001;  1: c4 = 4'b1010;  2: c4 = 4'b0001;
                default: c4 = 4'b0010;
            endcase
            return {6'b100100, st, d, c4};
        end
        default: return {6'b100100, st, d, 4'b1111};                // PUSH or POP
    endcase
endfunction

// --------------------------------------------------
// Instruction-level model
// --------------------------------------------------
function automatic logic [7:0] model_read(input logic [15:0] a);
    return m_mem.exists(a) ? m_mem[a] : a[15:8] ^ a[7:0];
endfunction

// Returns {C, H, V, result} from the datasheet equations
function automatic logic [10:0] add_sub(input logic [7:0] a, input logic [7:0] b,
                                        input logic sub, input logic cin);
    logic [7:0] r;
    logic       c;
    logic       h;
    logic       v;
    if (sub) begin
        r = a - b - cin;
        c = (~a[7] & b[7]) | (b[7] & r[7]) | (r[7] & ~a[7]);
        h = (~a[3] & b[3]) | (b[3] & r[3]) | (r[3] & ~a[3]);
        v = (a[7] & ~b[7] & ~r[7]) | (~a[7] & b[7] & r[7]);
    end else begin
        r = a + b + cin;
        c = (a[7] & b[7]) | (b[7] & ~r[7]) | (~r[7] & a[7]);
        h = (a[3] & b[3]) | (b[3] & ~r[3]) | (~r[3] & a[3]);
        v = (a[7] & b[7] & ~r[7]) | (~a[7] & ~b[7] & r[7]);
    end
    return {c, h, v, r};
endfunction

task automatic update_flags(input logic [7:0] res, input logic c, input logic h,
                            input logic v, input logic chain);
    m_sreg[FLAG_C] = c;
    m_sreg[FLAG_H] = h;
    m_sreg[FLAG_V] = v;
    m_sreg[FLAG_N] = res[7];
    m_sreg[FLAG_S] = res[7] ^ v;
    m_sreg[FLAG_Z] = (res == 8'h00) && (!chain || m_sreg[FLAG_Z]);  // Old Z for chains
endtask

task automatic arith(input logic [4:0] d, input logic [7:0] a, input logic [7:0] b,
                     input logic sub, input logic cin, input logic chain, input logic wr);
    logic [10:0] t;
    t = add_sub(a, b, sub, cin);
    update_flags(t[7:0], t[10], t[9], t[8], chain);
    if (wr) m_regs[d] = t[7:0];
endtask

task automatic logic_op(input logic [4:0] d, input logic [7:0] res);
    update_flags(res, m_sreg[FLAG_C], m_sreg[FLAG_H], 1'b0, 1'b0);
    m_regs[d] = res;
endtask

// Mode 0 is plain, 1 post-increment, 2 pre-decrement, 3 push and 4 pop
task automatic mem_access(input logic [4:0] d, input logic store, input int sel,
                          input int mode);
    logic [15:0] ptr;
    logic [15:0] ea;
    int          lo;
    lo  = 26 + 2 * sel;
    ptr = {m_regs[lo+1], m_regs[lo]};
    ea  = ptr;
    case (mode)
        1: ptr = ptr + 16'd1;
        2: begin
            ea  = ptr - 16'd1;
            ptr = ea;
        end
        3: ea = m_sp;
        4: ea = m_sp + 16'd1;
        default: ;
    endcase
    if (store) begin
        wr_pend   = 1'b1;
        wr_addr   = ea;
        wr_data   = m_regs[d];       // Value before any pointer update
        m_mem[ea] = m_regs[d];
    end else begin
        m_load_rd   = d;
        m_load_addr = ea;
        m_load_val  = model_read(ea);
        m_phase     = 1'b1;
    end
    if (mode == 1 || mode == 2) begin
        m_regs[lo]   = ptr[7:0];
        m_regs[lo+1] = ptr[15:8];
    end
    if (mode == 3) m_sp = m_sp - 16'd1;
    if (mode == 4) m_sp = m_sp + 16'd1;
endtask

// Advances the model by one cycle and leaves m_pc at the pc of the next cycle
task automatic step_model();
    logic [15:0] w;
    logic [15:0] nxt;
    logic [4:0]  d;
    logic [4:0]  dh;
    logic [7:0]  a;
    logic [7:0]  b;
    logic [7:0]  k;
    logic [7:0]  res;
    logic        cf;
    wr_pend = 1'b0;
    if (m_phase) begin                                  // Second cycle of LD and POP
        m_regs[m_load_rd] = m_load_val;
        m_phase = 1'b0;
        m_pc    = m_pc + 16'd1;
        return;
    end
    n_instr++;
    w   = imem_w[m_pc[9:0]];
    nxt = m_pc + 16'd1;
    d   = w[8:4];
    dh  = {1'b1, w[7:4]};
    a   = m_regs[d];
    b   = m_regs[{w[9], w[3:0]}];
    k   = {w[11:8], w[3:0]};
    cf  = m_sreg[FLAG_C];
    if (w[15:12] == 4'b1110) begin
        m_regs[dh] = k;
    end else if (w[15:12] <= 4'b0010) begin
        case (w[15:10])
            6'b000001: arith(d, a, b, 1'b1, cf, 1'b1, 1'b0);      // CPC
            6'b000010: arith(d, a, b, 1'b1, cf, 1'b1, 1'b1);      // SBC
            6'b000011: arith(d, a, b, 1'b0, 1'b0, 1'b0, 1'b1);
            6'b000101: arith(d, a, b, 1'b1, 1'b0, 1'b0, 1'b0);    // CP
            6'b000110: arith(d, a, b, 1'b1, 1'b0, 1'b0, 1'b1);
            6'b000111: arith(d, a, b, 1'b0, cf, 1'b0, 1'b1);      // ADC
            6'b001000: logic_op(d, a & b);
            6'b001001: logic_op(d, a ^ b);
            6'b001010: logic_op(d, a | b);
            6'b001011: m_regs[d] = b;                             // MOV
            default: ;
        endcase
    end else if (w[15:12] <= 4'b0111) begin
        case (w[15:12])
            4'b0011: arith(dh, m_regs[dh], k, 1'b1, 1'b0, 1'b0, 1'b0);
            4'b0100: arith(dh, m_regs[dh], k, 1'b1, cf, 1'b1, 1'b1);
            4'b0101: arith(dh, m_regs[dh], k, 1'b1, 1'b0, 1'b0, 1'b1);
            4'b0110: logic_op(dh, m_regs[dh] | k);
            default: logic_op(dh, m_regs[dh] & k);
        endcase
    end else if (w[15:9] == 7'b1001010) begin
        case (w[3:0])
            4'h0: begin
                update_flags(~a, 1'b1, m_sreg[FLAG_H], 1'b0, 1'b0);
                m_regs[d] = ~a;
            end
            4'h1: begin
                res = 8'h00 - a;
                update_flags(res, res != 8'h00, res[3] | a[3], res == 8'h80, 1'b0);
                m_regs[d] = res;
            end
            4'h2: m_regs[d] = {a[3:0], a[7:4]};
            4'h3, 4'hA: begin
                res = (w[3:0] == 4'h3) ? a + 8'd1 : a - 8'd1;
                update_flags(res, cf, m_sreg[FLAG_H],
                             res == ((w[3:0] == 4'h3) ? 8'h80 : 8'h7F), 1'b0);
                m_regs[d] = res;
            end
            4'h5, 4'h6, 4'h7: begin
                res = {(w[3:0] == 4'h5) ? a[7] : ((w[3:0] == 4'h7) & cf), a[7:1]};
                update_flags(res, a[0], m_sreg[FLAG_H], res[7] ^ a[0], 1'b0);
                m_regs[d] = res;
            end
            default: ;
        endcase
    end else if (w[15:12] == 4'b1100) begin
        nxt = nxt + {{4{w[11]}}, w[11:0]};
    end else if (w[15:11] == 5'b11110) begin
        if (m_sreg[w[2:0]] == ~w[10]) nxt = nxt + {{9{w[9]}}, w[9:3]};
    end else if (w[15:12] == 4'b1000 && w[11:10] == 2'b00 && w[2:0] == 3'b000) begin
        mem_access(d, w[9], w[3] ? 1 : 2, 0);
    end else if (w[15:10] == 6'b100100) begin
        case (w[3:0])
            4'b1100: mem_access(d, w[9], 0, 0);
            4'b1101: mem_access(d, w[9], 0, 1);
            4'b1110: mem_access(d, w[9], 0, 2);
            4'b1001: mem_access(d, w[9], 1, 1);
            4'b1010: mem_access(d, w[9], 1, 2);
            4'b0001: mem_access(d, w[9], 2, 1);
            4'b0010: mem_access(d, w[9], 2, 2);
            4'b1111: mem_access(d, w[9], 0, w[9] ? 3 : 4);
            default: ;
        endcase
    end
    if (!m_phase) m_pc = nxt;                          // PC holds in load phase 0
endtask

// ==== tb/avr_core_tb.sv ====
`timescale 1ns/1ps

module avr_core_tb;
    import avr_pkg::*;

    localparam int N_INSTR     = 2000;
    localparam int WATCHDOG_NS = (2 * N_INSTR + 30) * 10;

    logic              clock;
    logic              rst_n_i;
    logic [ADDR_W-1:0] pc_o;
    instr_u            instr_i;
    logic [ADDR_W-1:0] addr_o;
    logic [DATA_W-1:0] wdata_o;
    logic              wren_o;
    logic [DATA_W-1:0] rdata_i;

    integer            seed;
    int                n_instr;
    logic [15:0]       imem_w [1024];
    logic [7:0]        dmem [logic [15:0]];

    // Model state
    logic [7:0]        m_mem [logic [15:0]];
    logic [7:0]        m_regs [32];
    logic [7:0]        m_sreg;
    logic [15:0]       m_pc;
    logic [15:0]       m_sp;
    logic              m_phase;
    logic [4:0]        m_load_rd;
    logic [15:0]       m_load_addr;
    logic [7:0]        m_load_val;
    logic              wr_pend;
    logic [15:0]       wr_addr;
    logic [7:0]        wr_data;

    `include "avr_iss_model.svh"

    avr_core UUT (
        .clock(clock), .rst_n_i(rst_n_i), .pc_o(pc_o), .instr_i(instr_i),
        .addr_o(addr_o), .wdata_o(wdata_o), .wren_o(wren_o), .rdata_i(rdata_i)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_pc(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED pc_o got %h expected %h", got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_addr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED addr_o got %h expected %h (pc %h)", got, exp, pc_o);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED wdata_o got %h expected %h (pc %h)", got, exp, pc_o);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_wren(input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED wren_o got %h expected %h (pc %h)", got, exp, pc_o);
            $display("test failed");
            $fatal(1);
        end
    endtask

    function automatic logic [7:0] dut_read(input logic [15:0] a);
        return dmem.exists(a) ? dmem[a] : a[15:8] ^ a[7:0];
    endfunction

    // Outputs are stable at the falling edge
    task automatic check_cycle();
        check_pc(pc_o, m_pc);
        check_wren(wren_o, wr_pend);
        if (wr_pend) begin
            check_addr(addr_o, wr_addr);
            check_data(wdata_o, wr_data);
        end
        if (m_phase) check_addr(addr_o, m_load_addr);      // Load phase 1
    endtask

    task automatic drive_inputs();
        if (wren_o) dmem[addr_o] = wdata_o;
        instr_i = imem_w[pc_o[9:0]];
        rdata_i = dut_read(addr_o);
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        seed      = 32'h5818;
        rst_n_i   = 1'b0;
        instr_i   = '0;
        rdata_i   = '0;
        n_instr   = 0;
        for (int i = 0; i < 1024; i++) imem_w[i] = random_instr();
        for (int i = 0; i < 32; i++) m_regs[i] = 8'h00;
        m_sreg  = 8'h00;
        m_pc    = 16'h0000;
        m_sp    = SP_RESET;
        m_phase = 1'b0;
        wr_pend = 1'b0;

        repeat (5) @(negedge clock);
        rst_n_i = 1'b1;
        while (n_instr < N_INSTR || m_phase) begin
            check_cycle();
            step_model();
            drive_inputs();
            @(negedge clock);
        end
        check_cycle();

        $display("test passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS * 1ns);
        $display("Timeout: the run did not finish in the expected time");
        $display("test failed");
        $fatal(1);
    end

endmodule

// ==== rtl/avr_core.sv ====
`timescale 1ns/1ps

module avr_core (
    input  logic                        clock,
    input  logic                        rst_n_i,
    output logic [avr_pkg::ADDR_W-1:0]  pc_o,
    input  avr_pkg::instr_u             instr_i,
    output logic [avr_pkg::ADDR_W-1:0]  addr_o,
    output logic [avr_pkg::DATA_W-1:0]  wdata_o,
    output logic                        wren_o,
    input  logic [avr_pkg::DATA_W-1:0]  rdata_i
);
    import avr_pkg::*;

    // --------------------------------------------------
    // Decoder controls
    // --------------------------------------------------
    logic [ALU_OP_W-1:0]   alu_op;
    logic [REG_IDX_W-1:0]  rd_idx, rr_idx;
    logic [DATA_W-1:0]     imm;
    logic                  use_imm, reg_write, flag_write, load, store;
    logic [PTR_MODE_W-1:0] ptr_mode;
    logic [PTR_SEL_W-1:0]  ptr_sel, ptr_idx;
    logic                  branch, jump, br_set;
    logic [2:0]            br_flag;
    logic [ADDR_W-1:0]     offset;

    // Datapath
    logic [DATA_W-1:0]     rd_data, rr_data, alu_result, alu_sreg, sreg;
    logic [ADDR_W-1:0]     x_ptr, y_ptr, z_ptr, ptr_addr, ptr_new;
    logic                  ptr_write, commit, wr_en, pair_en;
    logic [REG_IDX_W-1:0]  wr_idx;
    logic [DATA_W-1:0]     wr_data;
    wire  [DATA_W-1:0]     alu_b = use_imm ? imm : rr_data;

    instr_decoder u_decoder (
        .instr_i(instr_i), .alu_op_o(alu_op), .rd_idx_o(rd_idx), .rr_idx_o(rr_idx),
        .imm_o(imm), .use_imm_o(use_imm), .reg_write_o(reg_write),
        .flag_write_o(flag_write), .load_o(load), .store_o(store),
        .ptr_mode_o(ptr_mode), .ptr_sel_o(ptr_sel), .branch_o(branch), .jump_o(jump),
        .br_flag_o(br_flag), .br_set_o(br_set), .offset_o(offset)
    );

    alu_unit u_alu (
        .op_i(alu_op), .a_i(rd_data), .b_i(alu_b), .sreg_i(sreg),
        .result_o(alu_result), .sreg_o(alu_sreg)
    );

    pointer_unit u_pointer (
        .clock(clock), .rst_n_i(rst_n_i), .mode_i(ptr_mode), .sel_i(ptr_sel),
        .x_i(x_ptr), .y_i(y_ptr), .z_i(z_ptr), .commit_i(commit),
        .addr_o(ptr_addr), .ptr_new_o(ptr_new), .ptr_idx_o(ptr_idx), .ptr_write_o(ptr_write)
    );

    register_file u_regs (
        .clock(clock), .rst_n_i(rst_n_i), .rd_idx_i(rd_idx), .rr_idx_i(rr_idx),
        .wr_en_i(wr_en), .wr_idx_i(wr_idx), .wr_data_i(wr_data),
        .pair_en_i(pair_en), .pair_idx_i(ptr_idx), .pair_data_i(ptr_new),
        .rd_data_o(rd_data), .rr_data_o(rr_data), .x_o(x_ptr), .y_o(y_ptr), .z_o(z_ptr)
    );

    core_sequencer u_seq (
        .clock(clock), .rst_n_i(rst_n_i), .rd_idx_i(rd_idx), .reg_write_i(reg_write),
        .flag_write_i(flag_write), .load_i(load), .store_i(store), .branch_i(branch),
        .jump_i(jump), .br_flag_i(br_flag), .br_set_i(br_set), .offset_i(offset),
        .alu_result_i(alu_result), .alu_sreg_i(alu_sreg), .ptr_addr_i(ptr_addr),
        .ptr_write_i(ptr_write), .rd_data_i(rd_data), .rdata_i(rdata_i),
        .pc_o(pc_o), .sreg_o(sreg), .commit_o(commit), .wr_en_o(wr_en),
        .wr_idx_o(wr_idx), .wr_data_o(wr_data), .pair_en_o(pair_en),
        .addr_o(addr_o), .wdata_o(wdata_o), .wren_o(wren_o)
    );

endmodule

// ==== rtl/core_sequencer.sv ====
`timescale 1ns/1ps

module core_sequencer (
    input  logic                            clock,
    input  logic                            rst_n_i,
    input  logic [avr_pkg::REG_IDX_W-1:0]   rd_idx_i,
    input  logic                            reg_write_i,
    input  logic                            flag_write_i,
    input  logic                            load_i,
    input  logic                            store_i,
    input  logic                            branch_i,
    input  logic                            jump_i,
    input  logic [2:0]                      br_flag_i,
    input  logic                            br_set_i,
    input  logic [avr_pkg::ADDR_W-1:0]      offset_i,
    input  logic [avr_pkg::DATA_W-1:0]      alu_result_i,
    input  logic [avr_pkg::DATA_W-1:0]      alu_sreg_i,
    input  logic [avr_pkg::ADDR_W-1:0]      ptr_addr_i,
    input  logic                            ptr_write_i,
    input  logic [avr_pkg::DATA_W-1:0]      rd_data_i,
    input  logic [avr_pkg::DATA_W-1:0]      rdata_i,
    output logic [avr_pkg::ADDR_W-1:0]      pc_o,
    output logic [avr_pkg::DATA_W-1:0]      sreg_o,
    output logic                            commit_o,
    output logic                            wr_en_o,
    output logic [avr_pkg::REG_IDX_W-1:0]   wr_idx_o,
    output logic [avr_pkg::DATA_W-1:0]      wr_data_o,
    output logic                            pair_en_o,
    output logic [avr_pkg::ADDR_W-1:0]      addr_o,
    output logic [avr_pkg::DATA_W-1:0]      wdata_o,
    output logic                            wren_o
);
    import avr_pkg::*;

    logic phase;    // Set in the second cycle of LD and POP
    logic taken;

    assign taken = jump_i | (branch_i & (sreg_o[br_flag_i] == br_set_i));

    // --------------------------------------------------
    // Write-back and pointer commit
    // --------------------------------------------------
    assign commit_o  = store_i | (load_i & ~phase);
    assign pair_en_o = commit_o & ptr_write_i;
    assign wr_en_o   = reg_write_i | (load_i & phase);
    assign wr_idx_o  = rd_idx_i;
    assign wr_data_o = load_i ? rdata_i : alu_result_i;

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            pc_o   <= '0;
            phase  <= 1'b0;
            sreg_o <= '0;
            wren_o <= 1'b0;
        end else begin
            wren_o <= store_i;
            if (flag_write_i) sreg_o <= alu_sreg_i;
            if (load_i && !phase) begin
                phase <= 1'b1;                  // PC holds, same word next cycle
            end else begin
                phase <= 1'b0;
                pc_o  <= pc_o + 1'b1 + (taken ? offset_i : '0);
            end
        end
    end

    // Data bus, one cycle behind the instruction
    always_ff @(posedge clock) begin
        if (commit_o) addr_o <= ptr_addr_i;
        if (store_i) wdata_o <= rd_data_i;
    end

endmodule

// ==== rtl/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic                            clock,
    input  logic                            rst_n_i,
    input  logic [avr_pkg::REG_IDX_W-1:0]   rd_idx_i,
    input  logic [avr_pkg::REG_IDX_W-1:0]   rr_idx_i,
    input  logic                            wr_en_i,
    input  logic [avr_pkg::REG_IDX_W-1:0]   wr_idx_i,
    input  logic [avr_pkg::DATA_W-1:0]      wr_data_i,
    input  logic                            pair_en_i,
    input  logic [avr_pkg::PTR_SEL_W-1:0]   pair_idx_i,
    input  logic [avr_pkg::ADDR_W-1:0]      pair_data_i,
    output logic [avr_pkg::DATA_W-1:0]      rd_data_o,
    output logic [avr_pkg::DATA_W-1:0]      rr_data_o,
    output logic [avr_pkg::ADDR_W-1:0]      x_o,
    output logic [avr_pkg::ADDR_W-1:0]      y_o,
    output logic [avr_pkg::ADDR_W-1:0]      z_o
);
    import avr_pkg::*;

    logic [DATA_W-1:0]    regs [REG_COUNT];
    logic [REG_IDX_W-1:0] pair_lo;

    assign pair_lo = REG_IDX_W'(26) + {pair_idx_i, 1'b0};   // r26, r28 or r30

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            for (int i = 0; i < REG_COUNT; i++) regs[i] <= '0;
        end else begin
            if (pair_en_i) begin
                regs[pair_lo]        <= pair_data_i[DATA_W-1:0];
                regs[pair_lo + 1'b1] <= pair_data_i[ADDR_W-1:DATA_W];
            end
            if (wr_en_i) regs[wr_idx_i] <= wr_data_i;   // Byte write wins
        end
    end

    assign rd_data_o = regs[rd_idx_i];
    assign rr_data_o = regs[rr_idx_i];
    assign x_o = {regs[27], regs[26]};
    assign y_o = {regs[29], regs[28]};
    assign z_o = {regs[31], regs[30]};

endmodule

// ==== rtl/pointer_unit.sv ====
`timescale 1ns/1ps

module pointer_unit (
    input  logic                            clock,
    input  logic                            rst_n_i,
    input  logic [avr_pkg::PTR_MODE_W-1:0]  mode_i,
    input  logic [avr_pkg::PTR_SEL_W-1:0]   sel_i,
    input  logic [avr_pkg::ADDR_W-1:0]      x_i,
    input  logic [avr_pkg::ADDR_W-1:0]      y_i,
    input  logic [avr_pkg::ADDR_W-1:0]      z_i,
    input  logic                            commit_i,
    output logic [avr_pkg::ADDR_W-1:0]      addr_o,
    output logic [avr_pkg::ADDR_W-1:0]      ptr_new_o,
    output logic [avr_pkg::PTR_SEL_W-1:0]   ptr_idx_o,
    output logic                            ptr_write_o
);
    import avr_pkg::*;

    logic [ADDR_W-1:0] sp;
    logic [ADDR_W-1:0] ptr;

    always_comb begin
        case (sel_i)
            PTR_Y:   ptr = y_i;
            PTR_Z:   ptr = z_i;
            default: ptr = x_i;
        endcase
    end

    always_comb begin
        addr_o      = ptr;
        ptr_new_o   = ptr + 1'b1;
        ptr_write_o = 1'b0;
        case (mode_i)
            PTR_POSTINC: ptr_write_o = 1'b1;
            PTR_PREDEC: begin
                addr_o      = ptr - 1'b1;
                ptr_new_o   = ptr - 1'b1;
                ptr_write_o = 1'b1;
            end
            PTR_PUSH: addr_o = sp;
            PTR_POP:  addr_o = sp + 1'b1;
            default: ;
        endcase
    end

    assign ptr_idx_o = sel_i;   // Pair index for the register file

    // Stack pointer, post-decrement on PUSH
    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            sp <= SP_RESET;
        end else if (commit_i) begin
            if (mode_i == PTR_PUSH) sp <= sp - 1'b1;
            else if (mode_i == PTR_POP) sp <= sp + 1'b1;
        end
    end

endmodule

// ==== rtl/alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit (
    input  logic [avr_pkg::ALU_OP_W-1:0] op_i,
    input  logic [avr_pkg::DATA_W-1:0]   a_i,
    input  logic [avr_pkg::DATA_W-1:0]   b_i,
    input  logic [avr_pkg::DATA_W-1:0]   sreg_i,
    output logic [avr_pkg::DATA_W-1:0]   result_o,
    output logic [avr_pkg::DATA_W-1:0]   sreg_o
);
    import avr_pkg::*;

    logic [DATA_W-1:0] r;
    logic              c, h, v;
    logic              cin, shift_in;

    assign cin      = sreg_i[FLAG_C];
    assign shift_in = (op_i == ALU_ASR) ? a_i[7] : ((op_i == ALU_ROR) & cin);

    always_comb begin
        r = b_i;                // PASS moves operand b
        c = sreg_i[FLAG_C];
        h = sreg_i[FLAG_H];
        v = 1'b0;
        case (op_i)
            ALU_ADD, ALU_ADC: begin
                {c, r} = a_i + b_i + ((op_i == ALU_ADC) && cin);
                h = (a_i[3] & b_i[3]) | (b_i[3] & ~r[3]) | (~r[3] & a_i[3]);
                v = (a_i[7] & b_i[7] & ~r[7]) | (~a_i[7] & ~b_i[7] & r[7]);
            end
            ALU_SUB, ALU_SBC: begin
                {c, r} = a_i - b_i - ((op_i == ALU_SBC) && cin);  // Bit 8 is the borrow
                h = (~a_i[3] & b_i[3]) | (b_i[3] & r[3]) | (r[3] & ~a_i[3]);
                v = (a_i[7] & ~b_i[7] & ~r[7]) | (~a_i[7] & b_i[7] & r[7]);
            end
            ALU_AND: r = a_i & b_i;
            ALU_OR:  r = a_i | b_i;
            ALU_EOR: r = a_i ^ b_i;
            ALU_COM: begin
                r = ~a_i;
                c = 1'b1;
            end
            ALU_NEG: begin
                r = -a_i;
                h = r[3] | a_i[3];
                v = (r == 8'h80);
                c = (r != '0);
            end
            ALU_SWAP: r = {a_i[3:0], a_i[7:4]};
            ALU_INC: begin
                r = a_i + 1'b1;
                v = (r == 8'h80);
            end
            ALU_DEC: begin
                r = a_i - 1'b1;
                v = (r == 8'h7F);
            end
            ALU_ASR, ALU_LSR, ALU_ROR: begin
                r = {shift_in, a_i[7:1]};
                c = a_i[0];                 // Bit shifted out
                v = r[7] ^ a_i[0];
            end
            default: ;
        endcase

        result_o = r;
        sreg_o   = sreg_i;
        if (op_i != ALU_PASS && op_i != ALU_SWAP) begin
            sreg_o[FLAG_C] = c;
            sreg_o[FLAG_H] = h;
            sreg_o[FLAG_V] = v;
            sreg_o[FLAG_N] = r[7];
            sreg_o[FLAG_S] = r[7] ^ v;
            // SBC chains keep Z only if it was already set
            sreg_o[FLAG_Z] = (r == '0) && (op_i != ALU_SBC || sreg_i[FLAG_Z]);
        end
    end

endmodule

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
    input  avr_pkg::instr_u                  instr_i,
    output logic [avr_pkg::ALU_OP_W-1:0]     alu_op_o,
    output logic [avr_pkg::REG_IDX_W-1:0]    rd_idx_o,
    output logic [avr_pkg::REG_IDX_W-1:0]    rr_idx_o,
    output logic [avr_pkg::DATA_W-1:0]       imm_o,
    output logic                             use_imm_o,
    output logic                             reg_write_o,
    output logic                             flag_write_o,
    output logic                             load_o,
    output logic                             store_o,
    output logic [avr_pkg::PTR_MODE_W-1:0]   ptr_mode_o,
    output logic [avr_pkg::PTR_SEL_W-1:0]    ptr_sel_o,
    output logic                             branch_o,
    output logic                             jump_o,
    output logic [2:0]                       br_flag_o,
    output logic                             br_set_o,
    output logic [avr_pkg::ADDR_W-1:0]       offset_o
);
    import avr_pkg::*;

    always_comb begin
        alu_op_o     = ALU_PASS;
        rd_idx_o     = instr_i.r.rd;
        rr_idx_o     = {instr_i.r.rr_hi, instr_i.r.rr_lo};
        imm_o        = {instr_i.i.k_hi, instr_i.i.k_lo};
        use_imm_o    = 1'b0;
        reg_write_o  = 1'b0;
        flag_write_o = 1'b0;
        ptr_mode_o   = PTR_NONE;
        ptr_sel_o    = PTR_X;
        branch_o     = 1'b0;
        jump_o       = 1'b0;
        br_flag_o    = instr_i[2:0];
        br_set_o     = ~instr_i[10];   // BRBS when bit 10 clear
        offset_o     = {{(ADDR_W-7){instr_i[9]}}, instr_i[9:3]};

        case (instr_i.i.op)
            4'b0000, 4'b0001, 4'b0010: begin
                reg_write_o  = 1'b1;
                flag_write_o = 1'b1;
                case (instr_i.r.op)
                    6'b000001: begin alu_op_o = ALU_SBC; reg_write_o = 1'b0; end  // CPC
                    6'b000010: alu_op_o = ALU_SBC;
                    6'b000011: alu_op_o = ALU_ADD;
                    6'b000101: begin alu_op_o = ALU_SUB; reg_write_o = 1'b0; end  // CP
                    6'b000110: alu_op_o = ALU_SUB;
                    6'b000111: alu_op_o = ALU_ADC;
                    6'b001000: alu_op_o = ALU_AND;
                    6'b001001: alu_op_o = ALU_EOR;
                    6'b001010: alu_op_o = ALU_OR;
                    6'b001011: flag_write_o = 1'b0;     // MOV
                    default: begin reg_write_o = 1'b0; flag_write_o = 1'b0; end
                endcase
            end
            4'b0011, 4'b0100, 4'b0101, 4'b0110, 4'b0111: begin
                rd_idx_o     = {1'b1, instr_i.i.rd};
                use_imm_o    = 1'b1;
                flag_write_o = 1'b1;
                reg_write_o  = (instr_i.i.op != 4'b0011);  // CPI only compares
                case (instr_i.i.op)
                    4'b0100: alu_op_o = ALU_SBC;
                    4'b0110: alu_op_o = ALU_OR;
                    4'b0111: alu_op_o = ALU_AND;
                    default: alu_op_o = ALU_SUB;
                endcase
            end
            4'b1110: begin      // LDI
                rd_idx_o    = {1'b1, instr_i.i.rd};
                use_imm_o   = 1'b1;
                reg_write_o = 1'b1;
            end
            4'b1100: begin      // RJMP
                jump_o   = 1'b1;
                offset_o = {{(ADDR_W-12){instr_i[11]}}, instr_i[11:0]};
            end
            4'b1111: branch_o = ~instr_i[11];
            4'b1000: if (instr_i[11:10] == 2'b00 && instr_i[2:0] == 3'b000) begin
                ptr_mode_o = PTR_PLAIN;             // LD/ST Y or Z
                ptr_sel_o  = instr_i[3] ? PTR_Y : PTR_Z;
            end
            4'b1001: if (instr_i[11:10] == 2'b00) begin
                case (instr_i[3:0])
                    4'b1100: ptr_mode_o = PTR_PLAIN;
                    4'b1101: ptr_mode_o = PTR_POSTINC;
                    4'b1110: ptr_mode_o = PTR_PREDEC;
                    4'b1001: begin ptr_mode_o = PTR_POSTINC; ptr_sel_o = PTR_Y; end
                    4'b1010: begin ptr_mode_o = PTR_PREDEC;  ptr_sel_o = PTR_Y; end
                    4'b0001: begin ptr_mode_o = PTR_POSTINC; ptr_sel_o = PTR_Z; end
                    4'b0010: begin ptr_mode_o = PTR_PREDEC;  ptr_sel_o = PTR_Z; end
                    4'b1111: ptr_mode_o = instr_i[9] ? PTR_PUSH : PTR_POP;
                    default: ;
                endcase
            end else if (instr_i[11:9] == 3'b010) begin
                reg_write_o  = 1'b1;
                flag_write_o = 1'b1;
                case (instr_i[3:0])
                    4'b0000: alu_op_o = ALU_COM;
                    4'b0001: alu_op_o = ALU_NEG;
                    4'b0010: alu_op_o = ALU_SWAP;
                    4'b0011: alu_op_o = ALU_INC;
                    4'b0101: alu_op_o = ALU_ASR;
                    4'b0110: alu_op_o = ALU_LSR;
                    4'b0111: alu_op_o = ALU_ROR;
                    4'b1010: alu_op_o = ALU_DEC;
                    default: begin reg_write_o = 1'b0; flag_write_o = 1'b0; end
                endcase
            end
            default: ;          // Unknown words run as NOP
        endcase

        load_o  = (ptr_mode_o != PTR_NONE) && !instr_i[9];
        store_o = (ptr_mode_o != PTR_NONE) && instr_i[9];
    end

endmodule

// ==== rtl/avr_pkg.sv ====
package avr_pkg;

    // --------------------------------------------------
    // Widths and reset values
    // --------------------------------------------------
    localparam int DATA_W    = 8;
    localparam int ADDR_W    = 16;
    localparam int REG_IDX_W = 5;
    localparam int REG_COUNT = 32;

    // Top of the 8 KB stack
    localparam logic [ADDR_W-1:0] SP_RESET = 16'h1FFF;

    // --------------------------------------------------
    // ALU operation codes
    // --------------------------------------------------
    localparam int ALU_OP_W = 4;
    localparam logic [ALU_OP_W-1:0] ALU_PASS = 4'd0,  ALU_ADD = 4'd1,  ALU_ADC = 4'd2,
        ALU_SUB = 4'd3,  ALU_SBC = 4'd4,  ALU_AND = 4'd5,  ALU_OR  = 4'd6,  ALU_EOR = 4'd7,
        ALU_COM = 4'd8,  ALU_NEG = 4'd9,  ALU_SWAP = 4'd10, ALU_INC = 4'd11, ALU_DEC = 4'd12,
        ALU_ASR = 4'd13, ALU_LSR = 4'd14, ALU_ROR = 4'd15;

    // Pointer modes and pair selects
    localparam int PTR_MODE_W = 3;
    localparam int PTR_SEL_W  = 2;
    localparam logic [PTR_MODE_W-1:0] PTR_NONE = 3'd0, PTR_PLAIN = 3'd1, PTR_POSTINC = 3'd2,
        PTR_PREDEC = 3'd3, PTR_PUSH = 3'd4, PTR_POP = 3'd5;
    localparam logic [PTR_SEL_W-1:0] PTR_X = 2'd0, PTR_Y = 2'd1, PTR_Z = 2'd2;

    // SREG bit positions
    localparam int FLAG_C = 0, FLAG_Z = 1, FLAG_N = 2, FLAG_V = 3,
        FLAG_S = 4, FLAG_H = 5, FLAG_T = 6, FLAG_I = 7;

    // Instruction word, register and immediate views
    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic       rr_hi;
            logic [4:0] rd;
            logic [3:0] rr_lo;
        } r;
        struct packed {
            logic [3:0] op;
            logic [3:0] k_hi;
            logic [3:0] rd;     // r16..r31
            logic [3:0] k_lo;
        } i;
    } instr_u;

endpackage
